// ==== hw/memControl_config.svh ====
`ifndef MEM_CONTROL_CONFIG_SVH
`define MEM_CONTROL_CONFIG_SVH

// Memory function field of the microword
`define MEM_FIELD_W 4

// Magic number field, shared by the EA and conditional fetch views
`define MAGIC_W 9

// Held request word, same width as the PC flags it is muxed with
`define HELD_W 10

// Diagnostic readback slice
`define DIAG_W 4

`endif

// ==== hw/memControlPkg.sv ====
`include "memControl_config.svh"

package memControlPkg;

  // One-hot memory functions, group A then group B
  typedef struct packed {
    logic armIndirect;
    logic mbWait;
    logic restoreVma;
    logic aread;
    logic bWrite;
    logic condFetch;
    logic regFunc;
    logic adFunc;
    logic eaCalc;
    logic loadAr;
    logic loadArx;
    logic rwCycle;
    logic rpwCycle;
    logic write;
    logic uncondFetch;
  } memFuncT;

  // Cycle type requested from the memory box
  typedef struct packed {
    logic loadAr;
    logic loadArx;
    logic pause;
    logic write;
  } memReqT;

  typedef struct packed {
    logic user;
    logic public;
    logic previous;
    logic extended;
  } vmaCtxT;

  // Magic field as seen by an EA calculation
  typedef struct packed {
    memReqT req;
    logic spare1;
    logic longEa;
    logic [`MAGIC_W-8:0] spare2;
    logic previous;
  } eaMagicT;

  // Magic field as seen by a conditional fetch
  typedef struct packed {
    logic fetchOn;
    logic [3:0] spare1;
    logic testSkip;
    logic [`MAGIC_W-7:0] spare2;
  } condMagicT;

  typedef union packed {
    eaMagicT ea;
    condMagicT cond;
  } magicU;

endpackage

// ==== hw/memFuncDecode.sv ====
`timescale 1ns/1ps
`include "memControl_config.svh"

module memFuncDecode (
  input  logic [0:`MEM_FIELD_W-1] memField,
  output memControlPkg::memFuncT   mf
);

  logic [0:7] groupA;
  logic [0:7] groupB;

  // Enabled 3-to-8 decoder, output 0 is the leftmost bit
  function automatic logic [0:7] decode8(input logic en, input logic [0:2] sel);
    logic [0:7] q;
    q = '0;
    if (en) begin
      q[sel] = 1'b1;
    end
    return q;
  endfunction

  // Top bit picks which decoder is enabled
  always_comb begin
    groupA = decode8(~memField[0], memField[1:3]);
    groupB = decode8(memField[0], memField[1:3]);
  end

  // Group A code 0 means no memory function
  always_comb begin
    mf = {groupA[1:7], groupB};
  end

  always_comb begin
    assert ($onehot0(mf))
      else $error("memFuncDecode: more than one memory function for %b", memField);
  end

endmodule

// ==== hw/cycleRequest.sv ====
`timescale 1ns/1ps
`include "memControl_config.svh"

module cycleRequest (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [0:`MEM_FIELD_W-1]      memField,
  input  memControlPkg::memFuncT       mf,
  input  memControlPkg::magicU         magic,
  input  logic [1:12]                  ad,
  input  logic [0:2]                   dramA,
  input  logic                         testSatisfied,
  output memControlPkg::memReqT        req,
  output logic                         vmaFetch,
  output logic                         storeAr,
  output logic                         mboxCycReq,
  output logic                         skipSatisfied
);

  logic reqEn;
  logic areadLoadAr;
  logic areadLoadArx;
  logic areadPause;
  logic areadWrite;
  logic areadCycle;
  logic fetchTerm;
  memControlPkg::memReqT gatedEa;
  memControlPkg::memReqT gatedAd;
  memControlPkg::memReqT fixedReq;
  memControlPkg::memReqT nextReq;

  assign reqEn = |memField;

  // DRAM A field qualifies the aread function
  assign areadLoadAr = mf.aread & dramA[0];
  assign areadLoadArx = mf.aread & (dramA == 3'd1);
  assign areadPause = mf.aread & (dramA == 3'd7);
  assign areadWrite = mf.aread & ((dramA == 3'd3) | (dramA == 3'd6) | (dramA == 3'd7));
  assign areadCycle = mf.aread & (dramA != 3'd0) & (dramA != 3'd2);

  assign skipSatisfied = mf.condFetch & magic.cond.testSkip & testSatisfied;

  always_comb begin
    gatedEa = mf.eaCalc ? magic.ea.req : '0;
    gatedAd = mf.adFunc ? memControlPkg::memReqT'(ad[1:4]) : '0;
    fixedReq.loadAr = mf.loadAr | mf.rwCycle | mf.rpwCycle | areadLoadAr;
    fixedReq.loadArx = mf.loadArx | mf.uncondFetch | areadLoadArx;
    fixedReq.pause = mf.rpwCycle | areadPause;
    fixedReq.write = mf.write | mf.rwCycle | mf.rpwCycle | mf.bWrite | areadWrite;
    nextReq = gatedEa | gatedAd | fixedReq;
  end

  assign fetchTerm = mf.uncondFetch | areadLoadArx | (mf.adFunc & ad[9]) | skipSatisfied;

  always_ff @(posedge clk) begin
    if (reset) begin
      req <= '0;
      vmaFetch <= 1'b0;
    end else if (reqEn) begin
      req <= nextReq;
      vmaFetch <= fetchTerm;
    end
  end

  // Every group B function needs the memory box
  assign mboxCycReq = memField[0] | areadCycle | mf.condFetch;

  // Read-pause-write with no AR or ARX load
  assign storeAr = req.pause & req.write & ~req.loadAr & ~req.loadArx;

  storeArWrites: assert property (@(posedge clk) disable iff (reset)
    storeAr |-> req.write)
    else $error("cycleRequest: storeAr without a write cycle");

endmodule

// ==== hw/vmaContext.sv ====
`timescale 1ns/1ps
`include "memControl_config.svh"

module vmaContext (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [0:1]              vmaField,
  input  memControlPkg::memFuncT  mf,
  input  memControlPkg::magicU    magic,
  input  logic [1:12]             ad,
  input  logic                    userMode,
  input  logic                    publicMode,
  input  logic                    skipSatisfied,
  output logic                    loadVma,
  output memControlPkg::vmaCtxT   ctx,
  output logic                    adrErr
);

  memControlPkg::vmaCtxT nextCtx;
  logic longEaCalc;
  logic badSection;
  logic nextAdrErr;

  // A satisfied skip leaves the VMA alone
  assign loadVma = (|vmaField) & ~skipSatisfied;

  always_comb begin
    nextCtx.user = userMode | (mf.adFunc & ad[5]);
    nextCtx.public = publicMode | (mf.adFunc & ad[6]);
    nextCtx.previous = (mf.adFunc & ad[7]) | (mf.eaCalc & magic.ea.previous);
    nextCtx.extended = mf.adFunc & ad[8];
  end

  assign longEaCalc = mf.eaCalc & magic.ea.longEa;

  // Section number out of range for a long EA
  assign badSection = (|ad[6:11]) | ~ad[12];

  assign nextAdrErr = longEaCalc & badSection & ~mf.adFunc;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctx <= '0;
      adrErr <= 1'b0;
    end else if (loadVma) begin
      ctx <= nextCtx;
      adrErr <= nextAdrErr;
    end
  end

  adrErrOnLoad: assert property (@(posedge clk) disable iff (reset)
    $rose(adrErr) |-> $past(loadVma))
    else $error("vmaContext: adrErr rose without a VMA load");

endmodule

// ==== hw/heldDiag.sv ====
`timescale 1ns/1ps
`include "memControl_config.svh"

module heldDiag (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    loadHeld,
  input  logic                    condSelVma,
  input  logic [0:`HELD_W-1]      pcFlags,
  input  memControlPkg::memReqT   req,
  input  memControlPkg::vmaCtxT   ctx,
  input  logic                    vmaFetch,
  input  logic                    adrErr,
  input  logic                    mboxCycReq,
  input  logic                    loadVma,
  input  logic                    diagRead,
  input  logic [0:2]              diagSel,
  output logic [0:`HELD_W-1]      heldOrPc,
  output logic [0:`DIAG_W-1]      diagData
);

  logic [0:`HELD_W-1] held;

  // Snapshot of the last request, kept for trap recovery
  always_ff @(posedge clk) begin
    if (reset) begin
      held <= '0;
    end else if (loadHeld) begin
      held <= {req, ctx, vmaFetch, adrErr};
    end
  end

  assign heldOrPc = condSelVma ? held : pcFlags;

  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: diagData = heldOrPc[0:3];
        3'd1: diagData = heldOrPc[4:7];
        3'd2: diagData = req;
        3'd3: diagData = ctx;
        3'd4: diagData = {vmaFetch, adrErr, mboxCycReq, loadVma};
        // Unused selects read back as zero
        default: diagData = '0;
      endcase
    end
  end

  diagQuiet: assert property (@(posedge clk) disable iff (reset)
    !diagRead |-> (diagData == '0))
    else $error("heldDiag: diagnostic bus driven without diagRead");

endmodule

// ==== hw/memControl.sv ====
`timescale 1ns/1ps
`include "memControl_config.svh"

module memControl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [0:`MEM_FIELD_W-1]     memField,
  input  memControlPkg::magicU        magic,
  input  logic [0:1]                  vmaField,
  input  logic [1:12]                 ad,
  input  logic [0:2]                  dramA,
  input  logic                        testSatisfied,
  input  logic                        userMode,
  input  logic                        publicMode,
  input  logic                        loadHeld,
  input  logic                        condSelVma,
  input  logic [0:`HELD_W-1]          pcFlags,
  input  logic                        diagRead,
  input  logic [0:2]                  diagSel,
  output memControlPkg::memReqT       req,
  output logic                        vmaFetch,
  output logic                        storeAr,
  output logic                        mboxCycReq,
  output logic                        loadVma,
  output memControlPkg::vmaCtxT       ctx,
  output logic                        adrErr,
  output logic [0:`HELD_W-1]          heldOrPc,
  output logic [0:`DIAG_W-1]          diagData
);

  memControlPkg::memFuncT mf;
  logic skipSatisfied;

  memFuncDecode i_memFuncDecode (
    .memField (memField),
    .mf       (mf)
  );

  cycleRequest i_cycleRequest (
    .clk           (clk),
    .reset         (reset),
    .memField      (memField),
    .mf            (mf),
    .magic         (magic),
    .ad            (ad),
    .dramA         (dramA),
    .testSatisfied (testSatisfied),
    .req           (req),
    .vmaFetch      (vmaFetch),
    .storeAr       (storeAr),
    .mboxCycReq    (mboxCycReq),
    .skipSatisfied (skipSatisfied)
  );

  vmaContext i_vmaContext (
    .clk           (clk),
    .reset         (reset),
    .vmaField      (vmaField),
    .mf            (mf),
    .magic         (magic),
    .ad            (ad),
    .userMode      (userMode),
    .publicMode    (publicMode),
    .skipSatisfied (skipSatisfied),
    .loadVma       (loadVma),
    .ctx           (ctx),
    .adrErr        (adrErr)
  );

  heldDiag i_heldDiag (
    .clk        (clk),
    .reset      (reset),
    .loadHeld   (loadHeld),
    .condSelVma (condSelVma),
    .pcFlags    (pcFlags),
    .req        (req),
    .ctx        (ctx),
    .vmaFetch   (vmaFetch),
    .adrErr     (adrErr),
    .mboxCycReq (mboxCycReq),
    .loadVma    (loadVma),
    .diagRead   (diagRead),
    .diagSel    (diagSel),
    .heldOrPc   (heldOrPc),
    .diagData   (diagData)
  );

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic reset
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for the first 5 rising edges
  initial begin
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== tb/memControlTb.sv ====
`timescale 1ns/1ps
`include "memControl_config.svh"

module memControlTb;

  localparam int randomCycles = 2000;
  // Reset and about 200 directed cycles on top of the random run
  localparam int cycleLimit = randomCycles + 500;

  logic clk;
  logic reset;
  logic [0:`MEM_FIELD_W-1] memField;
  memControlPkg::magicU magic;
  logic [0:1] vmaField;
  logic [1:12] ad;
  logic [0:2] dramA;
  logic testSatisfied;
  logic userMode;
  logic publicMode;
  logic loadHeld;
  logic condSelVma;
  logic [0:`HELD_W-1] pcFlags;
  logic diagRead;
  logic [0:2] diagSel;
  memControlPkg::memReqT req;
  logic vmaFetch;
  logic storeAr;
  logic mboxCycReq;
  logic loadVma;
  memControlPkg::vmaCtxT ctx;
  logic adrErr;
  logic [0:`HELD_W-1] heldOrPc;
  logic [0:`DIAG_W-1] diagData;

  memControlPkg::memReqT modelReq = '0;
  logic modelFetch = 1'b0;
  memControlPkg::vmaCtxT modelCtx = '0;
  logic modelAdrErr = 1'b0;
  logic [0:`HELD_W-1] modelHeld = '0;
  memControlPkg::memFuncT fn;
  logic [`MAGIC_W-1:0] magicBits;
  logic skip;
  logic expLoadVma;
  logic expMbox;
  logic [0:`HELD_W-1] expHeldOrPc;
  integer seed = 32'h9739;
  int errorCount = 0;
  int cycles = 0;

  clockGen i_clockGen (.clk(clk), .reset(reset));

  memControl i_memControl (.*);

  // Bit 0 of the field picks group B, codes 1 to 7 of group A map to flags 14 down to 8
  function automatic memControlPkg::memFuncT decode(input logic [3:0] code);
    logic [14:0] flags;
    flags = 15'd0;
    if (code[3]) begin
      flags = 15'h0080 >> code[2:0];
    end else if (code[2:0] != 3'd0) begin
      flags = 15'h4000 >> (code[2:0] - 3'd1);
    end
    return memControlPkg::memFuncT'(flags);
  endfunction

  // EA view carries its request in the top four magic bits
  function automatic memControlPkg::memReqT nextReq(input memControlPkg::memFuncT f,
      input logic [8:0] mg, input logic [1:12] a, input logic [2:0] dr);
    logic [3:0] r;
    r = 4'd0;
    if (f.eaCalc) r = r | mg[8:5];
    if (f.adFunc) r = r | a[1:4];
    if (f.loadAr || f.rwCycle || f.rpwCycle || (f.aread && dr >= 3'd4)) r[3] = 1'b1;
    if (f.loadArx || f.uncondFetch || (f.aread && dr == 3'd1)) r[2] = 1'b1;
    if (f.rpwCycle || (f.aread && dr == 3'd7)) r[1] = 1'b1;
    if (f.write || f.rwCycle || f.rpwCycle || f.bWrite ||
        (f.aread && (dr == 3'd3 || dr == 3'd6 || dr == 3'd7))) r[0] = 1'b1;
    return memControlPkg::memReqT'(r);
  endfunction

  function automatic logic nextFetch(input memControlPkg::memFuncT f, input logic [1:12] a,
      input logic [2:0] dr, input logic sk);
    return f.uncondFetch || (f.aread && dr == 3'd1) || (f.adFunc && a[9]) || sk;
  endfunction

  function automatic memControlPkg::vmaCtxT nextCtx(input memControlPkg::memFuncT f,
      input logic [8:0] mg, input logic [1:12] a, input logic user, input logic pub);
    memControlPkg::vmaCtxT c;
    c.user = user || (f.adFunc && a[5]);
    c.public = pub || (f.adFunc && a[6]);
    c.previous = (f.adFunc && a[7]) || (f.eaCalc && mg[0]);
    c.extended = f.adFunc && a[8];
    return c;
  endfunction

  // Long EA with a section outside the valid range
  function automatic logic nextAdrErr(input memControlPkg::memFuncT f, input logic [8:0] mg,
      input logic [1:12] a);
    return f.eaCalc && mg[3] && (a[6:11] != 6'd0 || !a[12]) && !f.adFunc;
  endfunction

  // Group B sits in the low eight flags
  function automatic logic mboxReq(input memControlPkg::memFuncT f, input logic [2:0] dr);
    return (f[7:0] != 8'd0) || (f.aread && dr != 3'd0 && dr != 3'd2) || f.condFetch;
  endfunction

  function automatic logic [0:3] diagWord(input logic rd, input logic [2:0] sel,
      input logic [0:9] hp, input logic [0:3] rq, input logic [0:3] cx, input logic [0:3] flags);
    if (!rd) return 4'd0;
    case (sel)
      3'd0: return hp[0:3];
      3'd1: return hp[4:7];
      3'd2: return rq;
      3'd3: return cx;
      3'd4: return flags;
      default: return 4'd0;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      errorCount++;
      $display("Mismatch %s: got %h, expected %h", name, got, want);
      $display("Errors found");
      $fatal(1, "Stopping at the first failed check");
    end
  endtask

  // Inputs only change on rising edges, so the falling edge sees stable values
  always @(negedge clk) begin
    fn = decode(memField);
    magicBits = magic;
    skip = fn.condFetch && magicBits[3] && testSatisfied;
    expLoadVma = (vmaField != 2'd0) && !skip;
    expMbox = mboxReq(fn, dramA);
    expHeldOrPc = condSelVma ? modelHeld : pcFlags;
    checkValue("req", 32'(req), 32'(modelReq));
    checkValue("vmaFetch", 32'(vmaFetch), 32'(modelFetch));
    checkValue("storeAr", 32'(storeAr), 32'(modelReq.pause && modelReq.write &&
        !modelReq.loadAr && !modelReq.loadArx));
    checkValue("mboxCycReq", 32'(mboxCycReq), 32'(expMbox));
    checkValue("loadVma", 32'(loadVma), 32'(expLoadVma));
    checkValue("ctx", 32'(ctx), 32'(modelCtx));
    checkValue("adrErr", 32'(adrErr), 32'(modelAdrErr));
    checkValue("heldOrPc", 32'(heldOrPc), 32'(expHeldOrPc));
    checkValue("diagData", 32'(diagData), 32'(diagWord(diagRead, diagSel, expHeldOrPc,
        modelReq, modelCtx, {modelFetch, modelAdrErr, expMbox, expLoadVma})));
    // Model registers take what the DUT loads on the next rising edge
    if (reset) begin
      modelReq <= '0;
      modelFetch <= 1'b0;
      modelCtx <= '0;
      modelAdrErr <= 1'b0;
      modelHeld <= '0;
    end else begin
      if (memField != 4'd0) begin
        modelReq <= nextReq(fn, magicBits, ad, dramA);
        modelFetch <= nextFetch(fn, ad, dramA, skip);
      end
      if (expLoadVma) begin
        modelCtx <= nextCtx(fn, magicBits, ad, userMode, publicMode);
        modelAdrErr <= nextAdrErr(fn, magicBits, ad);
      end
      if (loadHeld) modelHeld <= {modelReq, modelCtx, modelFetch, modelAdrErr};
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Errors found");
      $fatal(1, "Timeout after %0d cycles before the tests finished", cycles);
    end
  end

  task automatic randomizeInputs();
    logic [31:0] r1;
    logic [31:0] r2;
    @(posedge clk);
    r1 = $random(seed);
    r2 = $random(seed);
    memField <= r1[3:0];
    magic <= r1[12:4];
    vmaField <= r1[14:13];
    dramA <= r1[17:15];
    testSatisfied <= r1[18];
    userMode <= r1[19];
    publicMode <= r1[20];
    loadHeld <= r1[21];
    condSelVma <= r1[22];
    diagRead <= r1[23];
    diagSel <= r1[26:24];
    ad <= r2[11:0];
    pcFlags <= r2[21:12];
  endtask

  initial begin
    memField <= '0;
    magic <= '0;
    vmaField <= '0;
    ad <= '0;
    dramA <= '0;
    testSatisfied <= 1'b0;
    userMode <= 1'b0;
    publicMode <= 1'b0;
    loadHeld <= 1'b0;
    condSelVma <= 1'b1;
    pcFlags <= '0;
    diagRead <= 1'b0;
    diagSel <= '0;
    // Idle cycles after reset, registers read zero
    @(negedge reset);
    @(posedge clk);
    // Every function code with every dramA value, code 0 holds
    for (int code = 0; code < 16; code++) begin
      for (int d = 0; d < 8; d++) begin
        randomizeInputs();
        memField <= 4'(code);
        dramA <= 3'(d);
      end
    end
    // Conditional fetch over testSkip, testSatisfied and vmaField
    for (int i = 0; i < 16; i++) begin
      randomizeInputs();
      memField <= 4'd6;
      magic <= {5'b0, i[0], 3'b0};
      testSatisfied <= i[1];
      vmaField <= i[3:2];
    end
    // adFunc and long eaCalc, VMA loads then holds
    for (int i = 0; i < 40; i++) begin
      randomizeInputs();
      memField <= i[0] ? 4'd9 : 4'd8;
      vmaField <= i[4] ? 2'd0 : 2'd2;
      magic.ea.longEa <= 1'b1;
    end
    // Held word and every diagnostic select
    for (int i = 0; i < 16; i++) begin
      randomizeInputs();
      loadHeld <= (i % 4 == 0);
      diagRead <= i[3];
      diagSel <= i[2:0];
    end
    repeat (randomCycles) randomizeInputs();
    @(posedge clk);
    if (errorCount == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "%0d checks failed", errorCount);
    end
  end

endmodule

// ==== memControl.f ====
+incdir+hw
hw/memControlPkg.sv
hw/memFuncDecode.sv
hw/cycleRequest.sv
hw/vmaContext.sv
hw/heldDiag.sv
hw/memControl.sv
tb/clockGen.sv
tb/memControlTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= memControlTb
FILELIST  ?= memControl.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

# A $fatal in the run gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
